//--- compile.f
+incdir+common
common/cpu16_pkg.sv
common/cpu16_stage_if.sv
source/cpu16_fetch.sv
source/cpu16_decode.sv
source/cpu16_execute.sv
source/cpu16_result.sv
source/cpu16_top.sv
sim/cpu16_properties.sv
sim/cpu16_tb.sv

//--- Makefile
# Verilator build and run of the cpu16 testbench.

OBJ_DIR = obj_dir

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module cpu16_tb -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/Vcpu16_tb

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module cpu16_tb

clean:
	rm -rf $(OBJ_DIR)

.PHONY: all build run lint clean

//--- sim/cpu16_golden.txt
// words 0..2: program length, port-in reply count, port write count.
// then program words, port-in replies, and port writes as address data pairs.
25 02 0b
// ldi r1 05, ldi r2 0c, out r1 to port 1
7105 720c 9101
// add, sub, and, or, xor, shl, each echoed by out
1312 9302
2421 9403
3512 9504
4612 9605
5712 9706
6823 9807
// sub to zero, br z over a stray out
2911 8101 9f0f
// sub with borrow, br nz taken, br nc falls through to out r10
2a12 8201 9f0f 8401 9a08
// br c taken, br ns falls through to out r1
8301 9f0f 8601 9109
// br s taken, br always skips two
8501 9f0f 8002 9f0f 9f0f
// in and echo twice, then halt
ab0a 9b0b ac0c 9c0d
b000
// port-in replies in order
3c5a a5f0
// expected port writes, address then data
0001 0005
0002 0011
0003 0007
0004 0004
0005 000d
0006 0009
0007 0018
0008 fff9
0009 0005
000b 3c5a
000d a5f0

//--- sim/cpu16_tb.sv
`timescale 1ns/100ps
`include "cpu16_cfg.svh"

module cpu16_tb;

	localparam int golden_words = 256;
	localparam int clk_period = 20;
	// program words start after the three count words.
	localparam int prog_base = 3;

	logic CLK;
	logic rst_n;
	cpu16_pkg::addr_t memory_address;
	cpu16_pkg::word_t memory_in;
	logic memory_valid;
	logic memory_ready;
	logic [`CPU16_PORT_BITS - 1:0] port_address;
	cpu16_pkg::word_t port_out;
	cpu16_pkg::word_t port_in;
	logic port_rd;
	logic port_wr;
	logic halted;

	logic [15:0] golden [golden_words];
	int prog_len;
	int n_replies;
	int n_writes;
	int reply_base;
	int write_base;
	// next expected write and next reply.
	int widx;
	int ridx;
	logic [31:0] rand_state;
	// memory model and port responder state.
	logic req_active;
	int req_delay;
	logic reply_due;

	cpu16_top i_dut (
		.CLK(CLK), .rst_n(rst_n),
		.memory_address(memory_address), .memory_in(memory_in),
		.memory_valid(memory_valid), .memory_ready(memory_ready),
		.port_address(port_address), .port_out(port_out), .port_in(port_in),
		.port_rd(port_rd), .port_wr(port_wr), .halted(halted)
	);

	initial begin
		CLK = 1'b0;
		forever #(clk_period / 2) CLK = ~CLK;
	end

	task automatic abort_run();
		$display("Regression failed");
		$fatal(1, "simulation stopped after an error");
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// unused space decodes as out r15, so a runaway fetch shows up as a stray write.
	function automatic cpu16_pkg::word_t fetch_word(input cpu16_pkg::addr_t addr);
		if (int'(addr) < prog_len)
			return golden[prog_base + int'(addr)];
		else
			return {8'h9f, addr[15:8] ^ addr[7:0]};
	endfunction

	// ready after 0 to 3 cycles, dropped once the handshake edge has passed.
	task automatic serve_memory();
		if (memory_ready) begin
			memory_ready = 1'b0;
			req_active = 1'b0;
		end else if (memory_valid) begin
			if (!req_active) begin
				req_active = 1'b1;
				rand_state = lcg_next(rand_state);
				req_delay = int'(rand_state[31:30]);
			end
			if (req_delay == 0) begin
				memory_ready = 1'b1;
				memory_in = fetch_word(memory_address);
			end else begin
				req_delay--;
			end
		end
	endtask

	// the reply is presented in the cycle after port_rd.
	task automatic serve_port_read();
		if (reply_due) begin
			assert (ridx < n_replies) else begin
				$display("port read with no reply left in the golden data");
				abort_run();
			end
			port_in = golden[reply_base + ridx];
			ridx++;
		end
		reply_due = port_rd;
	endtask

	task automatic check_port_write();
		logic [15:0] exp_addr;
		cpu16_pkg::word_t exp_data;
		if (port_wr) begin
			assert (widx < n_writes) else begin
				$display("port write beyond the %0d expected writes", n_writes);
				abort_run();
			end
			exp_addr = golden[write_base + 2 * widx];
			exp_data = golden[write_base + 2 * widx + 1];
			assert (port_address == exp_addr) else begin
				$display("ERROR: port_address is %h, expected %h", port_address, exp_addr);
				abort_run();
			end
			assert (port_out == exp_data) else begin
				$display("ERROR: port_out is %h, expected %h", port_out, exp_data);
				abort_run();
			end
			widx++;
		end
	endtask

	// allows twenty cycles per program word.
	initial begin
		@(posedge rst_n);
		repeat (prog_len * 20) @(posedge CLK);
		$display("the core did not halt within %0d cycles", prog_len * 20);
		abort_run();
	end

	initial begin
		$readmemh("sim/cpu16_golden.txt", golden);
		prog_len = int'(golden[0]);
		n_replies = int'(golden[1]);
		n_writes = int'(golden[2]);
		reply_base = prog_base + prog_len;
		write_base = reply_base + n_replies;
		widx = 0;
		ridx = 0;
		rand_state = 32'hcd97463b;
		req_active = 1'b0;
		req_delay = 0;
		reply_due = 1'b0;
		rst_n = 1'b0;
		memory_in = '0;
		memory_ready = 1'b0;
		port_in = '0;
		repeat (3) @(posedge CLK);
		#2;
		assert (!memory_valid && !port_wr && !port_rd && !halted) else begin
			$display("bus outputs not idle during reset");
			abort_run();
		end
		rst_n = 1'b1;
		while (!halted) begin
			@(posedge CLK);
			#2;
			serve_memory();
			serve_port_read();
			check_port_write();
		end
		// the core stays quiet once halted.
		repeat (4) begin
			@(posedge CLK);
			#2;
			assert (!memory_valid && !port_wr && !port_rd) else begin
				$display("bus activity after halted was raised");
				abort_run();
			end
		end
		if (widx == n_writes && ridx == n_replies) begin
			$display("Regression passed");
			$finish;
		end else begin
			$display("halted after %0d of %0d writes and %0d of %0d replies",
				widx, n_writes, ridx, n_replies);
			abort_run();
		end
	end

endmodule

//--- sim/cpu16_properties.sv
`timescale 1ns/100ps

module cpu16_properties (
	input logic             CLK,
	input logic             rst_n,
	input cpu16_pkg::addr_t memory_address,
	input logic             memory_valid,
	input logic             memory_ready,
	input logic             port_rd,
	input logic             port_wr,
	input logic             halted
);

	// a pending request keeps its address until the ready edge.
	a_addr_hold: assert property (@(posedge CLK) disable iff (!rst_n)
		memory_valid && !memory_ready |=> memory_valid && $stable(memory_address))
		else $error("instruction request dropped or moved before ready");

	// port strobes never overlap.
	a_port_excl: assert property (@(posedge CLK) disable iff (!rst_n) !(port_rd && port_wr))
		else $error("port_rd and port_wr high together");

	// each strobe lasts a single cycle.
	a_wr_pulse: assert property (@(posedge CLK) disable iff (!rst_n) port_wr |=> !port_wr)
		else $error("port_wr held longer than one cycle");
	a_rd_pulse: assert property (@(posedge CLK) disable iff (!rst_n) port_rd |=> !port_rd)
		else $error("port_rd held longer than one cycle");

	// no fetch once halted, and halted sticks.
	a_halt_quiet: assert property (@(posedge CLK) disable iff (!rst_n) halted |-> !memory_valid)
		else $error("instruction request while halted");
	a_halt_sticky: assert property (@(posedge CLK) disable iff (!rst_n) halted |=> halted)
		else $error("halted dropped before reset");

endmodule

bind cpu16_top cpu16_properties i_props (
	.CLK(CLK), .rst_n(rst_n),
	.memory_address(memory_address), .memory_valid(memory_valid),
	.memory_ready(memory_ready), .port_rd(port_rd), .port_wr(port_wr),
	.halted(halted)
);

//--- source/cpu16_top.sv
`timescale 1ns/100ps
`include "cpu16_cfg.svh"

module cpu16_top (
	input  logic                           CLK,
	input  logic                           rst_n,

	output cpu16_pkg::addr_t               memory_address,
	input  cpu16_pkg::word_t               memory_in,
	output logic                           memory_valid,
	input  logic                           memory_ready,

	output logic [`CPU16_PORT_BITS - 1:0]  port_address,
	output cpu16_pkg::word_t               port_out,
	input  cpu16_pkg::word_t               port_in,
	output logic                           port_rd,
	output logic                           port_wr,

	output logic                           halted
);

	// fetch to decode.
	logic instr_valid;
	cpu16_pkg::word_t instr;
	cpu16_pkg::addr_t instr_pc;

	// execute back to fetch.
	logic branch_taken;
	cpu16_pkg::addr_t branch_target;
	logic halt;

	// result back to fetch and the register file.
	logic done;
	logic wr_en;
	cpu16_pkg::reg_sel_t wr_sel;
	cpu16_pkg::word_t wr_data;

	cpu16_stage_if dec_ex ();
	cpu16_stage_if ex_res ();

	cpu16_fetch cpu_fet0 (
		.CLK(CLK), .rst_n(rst_n),
		.memory_address(memory_address), .memory_in(memory_in),
		.memory_valid(memory_valid), .memory_ready(memory_ready),
		.instr_valid(instr_valid), .instr(instr), .instr_pc(instr_pc),
		.branch_taken(branch_taken), .branch_target(branch_target),
		.halt(halt), .done(done), .halted(halted)
	);

	cpu16_decode cpu_dec0 (
		.CLK(CLK), .rst_n(rst_n),
		.instr_valid(instr_valid), .instr(instr), .instr_pc(instr_pc),
		.wr_en(wr_en), .wr_sel(wr_sel), .wr_data(wr_data),
		.s(dec_ex.sender)
	);

	cpu16_execute cpu_exec0 (
		.CLK(CLK), .rst_n(rst_n),
		.d(dec_ex.receiver), .r(ex_res.sender),
		.port_address(port_address), .port_out(port_out),
		.port_rd(port_rd), .port_wr(port_wr),
		.branch_taken(branch_taken), .branch_target(branch_target), .halt(halt)
	);

	cpu16_result cpu_res0 (
		.CLK(CLK), .rst_n(rst_n),
		.x(ex_res.receiver), .port_in(port_in),
		.wr_en(wr_en), .wr_sel(wr_sel), .wr_data(wr_data), .done(done)
	);

endmodule

//--- source/cpu16_result.sv
`timescale 1ns/100ps

module cpu16_result (
	input  logic                   CLK,
	input  logic                   rst_n,
	cpu16_stage_if.receiver        x,
	input  cpu16_pkg::word_t       port_in,
	output logic                   wr_en,
	output cpu16_pkg::reg_sel_t    wr_sel,
	output cpu16_pkg::word_t       wr_data,
	output logic                   done
);

	logic writes;
	logic take_port;
	cpu16_pkg::word_t wb_value;

	// instructions that produce a register value.
	always_comb begin
		case (x.opcode)
			cpu16_pkg::op_add, cpu16_pkg::op_sub, cpu16_pkg::op_and,
			cpu16_pkg::op_or, cpu16_pkg::op_xor, cpu16_pkg::op_shl,
			cpu16_pkg::op_ldi, cpu16_pkg::op_in: writes = 1'b1;
			default: writes = 1'b0;
		endcase
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			wr_en <= 1'b0;
			done <= 1'b0;
			take_port <= 1'b0;
		end else begin
			wr_en <= x.valid && writes;
			// halt ends with halted instead.
			done <= x.valid && (x.opcode != cpu16_pkg::op_halt);
			take_port <= x.valid && (x.opcode == cpu16_pkg::op_in);
		end
	end

	always_ff @(posedge CLK) begin
		if (x.valid) begin
			wr_sel <= x.rd;
			wb_value <= x.ra_val;
		end
	end

	// port_in is valid in the cycle after port_rd.
	assign wr_data = take_port ? port_in : wb_value;

endmodule

//--- source/cpu16_execute.sv
`timescale 1ns/100ps
`include "cpu16_cfg.svh"

module cpu16_execute (
	input  logic                          CLK,
	input  logic                          rst_n,
	cpu16_stage_if.receiver               d,
	cpu16_stage_if.sender                 r,
	output logic [`CPU16_PORT_BITS - 1:0] port_address,
	output cpu16_pkg::word_t              port_out,
	output logic                          port_rd,
	output logic                          port_wr,
	output logic                          branch_taken,
	output cpu16_pkg::addr_t              branch_target,
	output logic                          halt
);

	// top bit is carry, borrow or the bit shifted out.
	logic [`CPU16_BITS:0] alu_wide;
	logic is_alu;
	logic cond_ok;
	logic flag_z;
	logic flag_c;
	logic flag_s;
	cpu16_pkg::addr_t target;

	always_comb begin
		is_alu = 1'b1;
		case (d.opcode)
			cpu16_pkg::op_add: alu_wide = {1'b0, d.ra_val} + {1'b0, d.rb_val};
			cpu16_pkg::op_sub: alu_wide = {1'b0, d.ra_val} - {1'b0, d.rb_val};
			cpu16_pkg::op_and: alu_wide = {1'b0, d.ra_val & d.rb_val};
			cpu16_pkg::op_or:  alu_wide = {1'b0, d.ra_val | d.rb_val};
			cpu16_pkg::op_xor: alu_wide = {1'b0, d.ra_val ^ d.rb_val};
			cpu16_pkg::op_shl: alu_wide = {d.ra_val, 1'b0};
			cpu16_pkg::op_ldi: begin
				// the immediate is zero extended and leaves the flags alone.
				alu_wide = {{(`CPU16_BITS - 7){1'b0}}, d.imm8};
				is_alu = 1'b0;
			end
			default: begin
				alu_wide = '0;
				is_alu = 1'b0;
			end
		endcase
	end

	always_comb begin
		case (cpu16_pkg::cond_t'(d.rd))
			cpu16_pkg::cond_always: cond_ok = 1'b1;
			cpu16_pkg::cond_z:      cond_ok = flag_z;
			cpu16_pkg::cond_nz:     cond_ok = !flag_z;
			cpu16_pkg::cond_c:      cond_ok = flag_c;
			cpu16_pkg::cond_nc:     cond_ok = !flag_c;
			cpu16_pkg::cond_s:      cond_ok = flag_s;
			cpu16_pkg::cond_ns:     cond_ok = !flag_s;
			default:                cond_ok = 1'b0;
		endcase
	end

	// signed offset from the address after the branch.
	assign target = d.pc + 1'b1 + {{(`CPU16_ADDR_BITS - 8){d.imm8[7]}}, d.imm8};

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			{flag_z, flag_c, flag_s} <= 3'b000;
			r.valid <= 1'b0;
			port_rd <= 1'b0;
			port_wr <= 1'b0;
			branch_taken <= 1'b0;
			halt <= 1'b0;
		end else begin
			// only alu operations move the flags.
			if (d.valid && is_alu) begin
				flag_z <= (alu_wide[`CPU16_BITS - 1:0] == '0);
				flag_c <= alu_wide[`CPU16_BITS];
				flag_s <= alu_wide[`CPU16_BITS - 1];
			end
			r.valid <= d.valid;
			port_wr <= d.valid && (d.opcode == cpu16_pkg::op_out);
			port_rd <= d.valid && (d.opcode == cpu16_pkg::op_in);
			branch_taken <= d.valid && (d.opcode == cpu16_pkg::op_br) && cond_ok;
			halt <= d.valid && (d.opcode == cpu16_pkg::op_halt);
		end
	end

	always_ff @(posedge CLK) begin
		if (d.valid) begin
			r.opcode <= d.opcode;
			r.rd <= d.rd;
			r.ra_val <= alu_wide[`CPU16_BITS - 1:0];
			// no second operand past this stage.
			r.rb_val <= '0;
			r.imm8 <= d.imm8;
			r.port_num <= d.port_num;
			r.pc <= d.pc;
			port_address <= {{(`CPU16_PORT_BITS - `CPU16_REG_BITS){1'b0}}, d.port_num};
			// decode put rd on port a for out.
			port_out <= d.ra_val;
			branch_target <= target;
		end
	end

endmodule

//--- source/cpu16_decode.sv
`timescale 1ns/100ps
`include "cpu16_cfg.svh"

module cpu16_decode (
	input  logic                   CLK,
	input  logic                   rst_n,
	input  logic                   instr_valid,
	input  cpu16_pkg::word_t       instr,
	input  cpu16_pkg::addr_t       instr_pc,
	input  logic                   wr_en,
	input  cpu16_pkg::reg_sel_t    wr_sel,
	input  cpu16_pkg::word_t       wr_data,
	cpu16_stage_if.sender          s
);

	localparam int reg_count = 2 ** `CPU16_REG_BITS;

	cpu16_pkg::word_t regs [reg_count];
	cpu16_pkg::opcode_t opcode;
	cpu16_pkg::reg_sel_t rd;
	cpu16_pkg::reg_sel_t ra;
	cpu16_pkg::reg_sel_t rb;
	cpu16_pkg::reg_sel_t a_sel;

	// field split.
	assign opcode = cpu16_pkg::opcode_t'(instr[15:12]);
	assign rd = instr[11:8];
	assign ra = instr[7:4];
	assign rb = instr[3:0];

	// out reads rd on port a and all other opcodes read ra.
	assign a_sel = (opcode == cpu16_pkg::op_out) ? rd : ra;

	// register file with one write port from result.
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < reg_count; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_sel] <= wr_data;
		end
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n)
			s.valid <= 1'b0;
		else
			s.valid <= instr_valid;
	end

	// two read ports sampled with the instruction.
	always_ff @(posedge CLK) begin
		if (instr_valid) begin
			s.opcode <= opcode;
			s.rd <= rd;
			s.ra_val <= regs[a_sel];
			s.rb_val <= regs[rb];
			s.imm8 <= instr[7:0];
			// port number sits in the rb field.
			s.port_num <= rb;
			s.pc <= instr_pc;
		end
	end

endmodule

//--- source/cpu16_fetch.sv
`timescale 1ns/100ps
`include "cpu16_cfg.svh"

module cpu16_fetch (
	input  logic                  CLK,
	input  logic                  rst_n,
	output cpu16_pkg::addr_t      memory_address,
	input  cpu16_pkg::word_t      memory_in,
	output logic                  memory_valid,
	input  logic                  memory_ready,
	output logic                  instr_valid,
	output cpu16_pkg::word_t      instr,
	output cpu16_pkg::addr_t      instr_pc,
	input  logic                  branch_taken,
	input  cpu16_pkg::addr_t      branch_target,
	input  logic                  halt,
	input  logic                  done,
	output logic                  halted
);

	cpu16_pkg::fetch_state_t state;
	cpu16_pkg::addr_t pc;
	// branch target held from execute until done arrives.
	cpu16_pkg::addr_t target;
	logic br_pending;

	// the address stays on the bus for the whole request.
	assign memory_address = pc;
	// decode captures the word at the ready edge.
	assign instr_valid = memory_valid && memory_ready;
	assign instr = memory_in;
	assign instr_pc = pc;
	assign halted = (state == cpu16_pkg::fetch_halted);

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state <= cpu16_pkg::fetch_request;
			pc <= `CPU16_RESET_PC;
			memory_valid <= 1'b0;
			br_pending <= 1'b0;
		end else begin
			if (branch_taken)
				br_pending <= 1'b1;
			case (state)
				cpu16_pkg::fetch_request: begin
					// the first request follows reset and holds until ready.
					if (instr_valid) begin
						memory_valid <= 1'b0;
						state <= cpu16_pkg::fetch_wait_done;
					end else begin
						memory_valid <= 1'b1;
					end
				end
				cpu16_pkg::fetch_wait_done: begin
					if (halt) begin
						state <= cpu16_pkg::fetch_halted;
					end else if (done) begin
						// the next address is the branch target or pc plus one.
						pc <= br_pending ? target : pc + 1'b1;
						br_pending <= 1'b0;
						memory_valid <= 1'b1;
						state <= cpu16_pkg::fetch_request;
					end
				end
				// stays here until reset.
				default: memory_valid <= 1'b0;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (branch_taken)
			target <= branch_target;
	end

endmodule

//--- common/cpu16_stage_if.sv
`timescale 1ns/100ps

// one decoded instruction passed between two stages.
interface cpu16_stage_if;

	// valid is a one cycle pulse with every field stable.
	logic valid;
	cpu16_pkg::opcode_t opcode;
	cpu16_pkg::reg_sel_t rd;
	// register a value before execute and the result after it.
	cpu16_pkg::word_t ra_val;
	cpu16_pkg::word_t rb_val;
	cpu16_pkg::imm8_t imm8;
	cpu16_pkg::reg_sel_t port_num;
	cpu16_pkg::addr_t pc;

	// the receiver always accepts, so no ready comes back.
	modport sender(output valid, opcode, rd, ra_val, rb_val, imm8, port_num, pc);
	modport receiver(input valid, opcode, rd, ra_val, rb_val, imm8, port_num, pc);

endinterface

//--- common/cpu16_pkg.sv
`include "cpu16_cfg.svh"

package cpu16_pkg;

	// data, address, register select and immediate widths.
	typedef logic [`CPU16_BITS - 1:0] word_t;
	typedef logic [`CPU16_ADDR_BITS - 1:0] addr_t;
	typedef logic [`CPU16_REG_BITS - 1:0] reg_sel_t;
	typedef logic [7:0] imm8_t;

	// instruction class in bits 15..12.
	typedef enum logic [3:0] {
		op_nop  = 4'h0,
		op_add  = 4'h1,
		op_sub  = 4'h2,
		op_and  = 4'h3,
		op_or   = 4'h4,
		op_xor  = 4'h5,
		op_shl  = 4'h6,
		op_ldi  = 4'h7,
		op_br   = 4'h8,
		op_out  = 4'h9,
		op_in   = 4'ha,
		op_halt = 4'hb
	} opcode_t;

	// branch condition in the rd field of br.
	typedef enum logic [3:0] {
		cond_always = 4'h0,
		cond_z      = 4'h1,
		cond_nz     = 4'h2,
		cond_c      = 4'h3,
		cond_nc     = 4'h4,
		cond_s      = 4'h5,
		cond_ns     = 4'h6
	} cond_t;

	// instruction bus request machine.
	typedef enum logic [1:0] {
		fetch_request,
		fetch_wait_done,
		fetch_halted
	} fetch_state_t;

endpackage

//--- common/cpu16_cfg.svh
`ifndef CPU16_CFG_SVH
`define CPU16_CFG_SVH

// width of a data word and of each register.
`define CPU16_BITS 16

// register select width, giving sixteen registers.
`define CPU16_REG_BITS 4

// instruction bus is word addressed.
`define CPU16_ADDR_BITS 16

// address of the first fetch after reset.
`define CPU16_RESET_PC 16'h0000

// width of the address presented on the port bus.
`define CPU16_PORT_BITS 16

`endif
